// File: tb.f
design/mm_pkg.sv
design/mm_regfile.sv
design/mm_mem_arbiter.sv
design/mm_scratchpad.sv
design/mm_loader.sv
design/mm_engine.sv
design/mm_storer.sv
design/mm_top.sv
sim/mm_tb_clock.sv
sim/mm_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mm_tb -f tb.f -o mm_sim
./obj_dir/mm_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi
exit 0

// File: sim/mm_tb.sv
// Testbench for the matrix-multiply accelerator; drives host ports and checks jobs against a reference
`timescale 1ns/100ps

module mm_tb;

  logic                          clk, rst_n;
  logic                          reg_req, reg_we, reg_rvalid;
  logic [mm_pkg::REG_ADDR_W-1:0] reg_addr;
  logic [mm_pkg::WORD_W-1:0]     reg_wdata, reg_rdata;
  logic                          mem_req, mem_we, mem_gnt, mem_rvalid;
  logic [mm_pkg::ADDR_W-1:0]     mem_addr;
  logic [mm_pkg::WORD_W-1:0]     mem_wdata, mem_rdata;
  logic                          busy, done;

  // Operands indexed [matrix][row][col] with X, W and Y as matrices 0 to 2
  logic [15:0] mats [3][4][4];
  logic [15:0] z_exp [4][4];
  // Last value the host wrote to each scratchpad word
  logic [31:0] shadow [256];
  logic        stop_reads;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          fail_tests = 0;
  int          done_pulses = 0;
  int          exp_done_cnt = 0;

  mm_tb_clock u_clock (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  mm_top u_mm_top (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .reg_req_i    ( reg_req    ),
    .reg_we_i     ( reg_we     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_rdata_o  ( reg_rdata  ),
    .reg_rvalid_o ( reg_rvalid ),
    .mem_req_i    ( mem_req    ),
    .mem_we_i     ( mem_we     ),
    .mem_addr_i   ( mem_addr   ),
    .mem_wdata_i  ( mem_wdata  ),
    .mem_gnt_o    ( mem_gnt    ),
    .mem_rdata_o  ( mem_rdata  ),
    .mem_rvalid_o ( mem_rvalid ),
    .busy_o       ( busy       ),
    .done_o       ( done       )
  );

  a_reset_idle: assert property (@(posedge clk)
      !rst_n |=> (!busy && !done && !reg_rvalid && !mem_rvalid))
    else begin
      err_cnt++;
      $display("Outputs were not idle after reset at %0t", $time);
    end

  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
    else begin
      err_cnt++;
      $display("Done pulse at %0t without busy in the cycle before", $time);
    end

  a_reg_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
      reg_rvalid == $past(reg_req && !reg_we))
    else begin
      err_cnt++;
      $display("Register read valid strobe out of step at %0t", $time);
    end

  a_host_grant: assert property (@(posedge clk) disable iff (!rst_n) mem_req |-> mem_gnt)
    else begin
      err_cnt++;
      $display("Host memory request not granted at %0t", $time);
    end

  a_mem_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
      mem_rvalid == $past(mem_req && mem_gnt && !mem_we))
    else begin
      err_cnt++;
      $display("Host memory read valid strobe out of step at %0t", $time);
    end

  always @(negedge clk) begin
    if (done === 1'b1) begin
      done_pulses++;
    end
  end

  // Hard limit on run length
  initial begin
    repeat (100000) @(posedge clk);
    $display("Run exceeded the cycle limit");
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      fail_tests++;
      $display("%s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_req   <= 1'b1;
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_req <= 1'b0;
    reg_we  <= 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    reg_req  <= 1'b1;
    reg_we   <= 1'b0;
    reg_addr <= addr;
    @(posedge clk);
    reg_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!reg_rvalid && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!reg_rvalid) begin
      err_cnt++;
      $display("Register read at %0t never returned valid data", $time);
    end
    data = reg_rdata;
  endtask

  task automatic mem_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    mem_req   <= 1'b1;
    mem_we    <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= data;
    @(negedge clk);
    check_word("host write grant", {31'd0, mem_gnt}, 32'd1);
    @(posedge clk);
    mem_req <= 1'b0;
    mem_we  <= 1'b0;
    shadow[addr] = data;
  endtask

  task automatic mem_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    mem_req  <= 1'b1;
    mem_we   <= 1'b0;
    mem_addr <= addr;
    @(negedge clk);
    check_word("host read grant", {31'd0, mem_gnt}, 32'd1);
    @(posedge clk);
    mem_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!mem_rvalid && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!mem_rvalid) begin
      err_cnt++;
      $display("Host memory read at %0t never returned valid data", $time);
    end
    data = mem_rdata;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!done && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      err_cnt++;
      $display("Job did not finish within 2000 cycles at %0t", $time);
    end
  endtask

  function automatic void randomize_mats();
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          mats[m][i][j] = 16'($urandom());
        end
      end
    end
  endfunction

  // Low 16 bits of sums and products do not depend on signedness
  function automatic void compute_reference();
    logic [15:0] acc;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        acc = mats[2][i][j];
        for (int k = 0; k < 4; k++) begin
          acc = acc + mats[0][i][k] * mats[1][k][j];
        end
        z_exp[i][j] = acc;
      end
    end
  endfunction

  // Two words per row with the lower column in the low half
  task automatic store_matrix(input int m, input logic [7:0] base);
    int r, c;
    for (int w = 0; w < 8; w++) begin
      r = w / 2;
      c = (w % 2) * 2;
      mem_write(base + 8'(w), {mats[m][r][c+1], mats[m][r][c]});
    end
  endtask

  task automatic check_result(input logic [7:0] zb);
    logic [31:0] data;
    int          r, c;
    for (int w = 0; w < 8; w++) begin
      r = w / 2;
      c = (w % 2) * 2;
      mem_read(zb + 8'(w), data);
      check_word("Z word", data, {z_exp[r][c+1], z_exp[r][c]});
    end
  endtask

  task automatic start_job(input logic [7:0] xb, input logic [7:0] wb,
                           input logic [7:0] yb, input logic [7:0] zb);
    store_matrix(0, xb);
    store_matrix(1, wb);
    store_matrix(2, yb);
    compute_reference();
    reg_write(mm_pkg::REG_X_BASE, {24'd0, xb});
    reg_write(mm_pkg::REG_W_BASE, {24'd0, wb});
    reg_write(mm_pkg::REG_Y_BASE, {24'd0, yb});
    reg_write(mm_pkg::REG_Z_BASE, {24'd0, zb});
    reg_write(mm_pkg::REG_TRIGGER, 32'd1);
    // Each trigger issued while idle completes exactly one job
    exp_done_cnt++;
  endtask

  task automatic register_access();
    logic [7:0]  bases [4];
    logic [31:0] data;
    int          e0;
    e0 = err_cnt;
    for (int r = 0; r < 4; r++) begin
      bases[r] = 8'($urandom());
      reg_write(mm_pkg::REG_X_BASE + 3'(r), {24'd0, bases[r]});
    end
    for (int r = 0; r < 4; r++) begin
      reg_read(mm_pkg::REG_X_BASE + 3'(r), data);
      check_word("base register", data, {24'd0, bases[r]});
    end
    reg_read(mm_pkg::REG_STATUS, data);
    check_word("status after reset", data, 32'd0);
    report_test("register access", e0);
  endtask

  task automatic host_memory_access();
    logic [7:0]  addrs [8];
    logic [31:0] data;
    int          e0;
    e0 = err_cnt;
    // Upper half of the scratchpad stays clear of job data
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 8'h80 | 8'($urandom());
      mem_write(addrs[i], $urandom());
    end
    for (int i = 0; i < 8; i++) begin
      mem_read(addrs[i], data);
      check_word("host read", data, shadow[addrs[i]]);
    end
    report_test("host memory access", e0);
  endtask

  task automatic identity_job();
    int e0;
    e0 = err_cnt;
    randomize_mats();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        mats[1][i][j] = (i == j) ? 16'd1 : 16'd0;
        mats[2][i][j] = 16'd0;
      end
    end
    start_job(8'h00, 8'h08, 8'h10, 8'h18);
    // Identity W with zero bias gives back X
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        z_exp[i][j] = mats[0][i][j];
      end
    end
    wait_done();
    check_result(8'h18);
    report_test("identity job", e0);
  endtask

  task automatic random_jobs();
    logic [7:0]  b [4];
    logic [31:0] data;
    int          e0;
    e0 = err_cnt;
    for (int j = 0; j < 3; j++) begin
      // Regions rotate roles from job to job
      for (int r = 0; r < 4; r++) begin
        b[r] = 8'h20 + 8'(8 * ((j + r) % 4));
      end
      randomize_mats();
      start_job(b[0], b[1], b[2], b[3]);
      wait_done();
      check_result(b[3]);
    end
    reg_read(mm_pkg::REG_STATUS, data);
    check_word("status after jobs", data, {16'd0, 8'(exp_done_cnt), 8'd0});
    report_test("random jobs", e0);
  endtask

  task automatic trigger_while_busy();
    logic [31:0] data;
    int          n, pulses, e0;
    e0 = err_cnt;
    randomize_mats();
    start_job(8'h40, 8'h48, 8'h50, 8'h58);
    n = 0;
    @(negedge clk);
    while (!busy && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!busy) begin
      err_cnt++;
      $display("Busy never rose after the trigger at %0t", $time);
    end
    pulses = done_pulses;
    reg_write(mm_pkg::REG_TRIGGER, 32'd1);
    wait_done();
    // Long enough for a second job to finish had one started
    repeat (200) @(negedge clk);
    check_word("done pulses", 32'(done_pulses - pulses), 32'd1);
    check_word("busy after job", {31'd0, busy}, 32'd0);
    reg_read(mm_pkg::REG_STATUS, data);
    check_word("status done count", data, {16'd0, 8'(exp_done_cnt), 8'd0});
    check_result(8'h58);
    report_test("trigger while busy", e0);
  endtask

  task automatic host_contention();
    logic [7:0]  a;
    logic [31:0] data;
    int          e0;
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      mem_write(8'hc0 + 8'(i), $urandom());
    end
    randomize_mats();
    start_job(8'h60, 8'h68, 8'h70, 8'h78);
    stop_reads = 1'b0;
    fork
      begin
        wait_done();
        stop_reads = 1'b1;
      end
      begin
        while (!stop_reads) begin
          a = 8'hc0 + 8'($urandom_range(7, 0));
          mem_read(a, data);
          check_word("host read during job", data, shadow[a]);
        end
      end
    join
    check_result(8'h78);
    report_test("contention", e0);
  endtask

  initial begin
    int n;
    void'($urandom(32'h0915_8d36));
    reg_req    <= 1'b0;
    reg_we     <= 1'b0;
    reg_addr   <= '0;
    reg_wdata  <= '0;
    mem_req    <= 1'b0;
    mem_we     <= 1'b0;
    mem_addr   <= '0;
    mem_wdata  <= '0;
    stop_reads = 1'b0;
    n = 0;
    @(posedge clk);
    while (!rst_n && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) begin
      err_cnt++;
      $display("Reset was never released");
    end
    register_access();
    host_memory_access();
    identity_job();
    random_jobs();
    trigger_while_busy();
    host_contention();
    $display("Tests run: 6, tests failed: %0d, checks: %0d, errors: %0d",
             fail_tests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/mm_tb_clock.sv
// Testbench clock and reset source; 10 ns clock, reset held low for the first 4 cycles
`timescale 1ns/100ps

module mm_tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: design/mm_top.sv
// Accelerator top level; connects register file, scratchpad arbiter, memory and the compute pipeline
`timescale 1ns/100ps

module mm_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Host register port
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [mm_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [mm_pkg::WORD_W-1:0]     reg_wdata_i,
  output logic [mm_pkg::WORD_W-1:0]     reg_rdata_o,
  output logic                          reg_rvalid_o,
  // Host memory port
  input  logic                          mem_req_i,
  input  logic                          mem_we_i,
  input  logic [mm_pkg::ADDR_W-1:0]     mem_addr_i,
  input  logic [mm_pkg::WORD_W-1:0]     mem_wdata_i,
  output logic                          mem_gnt_o,
  output logic [mm_pkg::WORD_W-1:0]     mem_rdata_o,
  output logic                          mem_rvalid_o,
  output logic                          busy_o,
  output logic                          done_o
);

  logic [mm_pkg::ADDR_W-1:0] x_base, w_base, y_base, z_base;
  logic                      start, load_done, calc_done, store_done;

  // Loader and storer memory requests
  logic                      ld_req, ld_gnt;
  logic [mm_pkg::ADDR_W-1:0] ld_addr;
  logic                      st_req, st_gnt;
  logic [mm_pkg::ADDR_W-1:0] st_addr;
  logic [mm_pkg::WORD_W-1:0] st_wdata;

  // Scratchpad side of the arbiter
  logic                      sp_en, sp_we;
  logic [mm_pkg::ADDR_W-1:0] sp_addr;
  logic [mm_pkg::WORD_W-1:0] sp_wdata, sp_rdata, rdata;

  mm_pkg::mat_t              x_mat, w_mat, y_mat, z_mat;

  assign mem_rdata_o = rdata;

  mm_regfile u_regfile (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .reg_req_i    ( reg_req_i    ),
    .reg_we_i     ( reg_we_i     ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .store_done_i ( store_done   ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .x_base_o     ( x_base       ),
    .w_base_o     ( w_base       ),
    .y_base_o     ( y_base       ),
    .z_base_o     ( z_base       ),
    .start_o      ( start        ),
    .busy_o       ( busy_o       ),
    .done_o       ( done_o       )
  );

  mm_mem_arbiter u_arbiter (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .host_req_i    ( mem_req_i    ),
    .host_we_i     ( mem_we_i     ),
    .host_addr_i   ( mem_addr_i   ),
    .host_wdata_i  ( mem_wdata_i  ),
    .host_gnt_o    ( mem_gnt_o    ),
    .host_rvalid_o ( mem_rvalid_o ),
    .ld_req_i      ( ld_req       ),
    .ld_we_i       ( 1'b0         ),
    .ld_addr_i     ( ld_addr      ),
    .ld_wdata_i    ( '0           ),
    .ld_gnt_o      ( ld_gnt       ),
    .st_req_i      ( st_req       ),
    .st_we_i       ( 1'b1         ),
    .st_addr_i     ( st_addr      ),
    .st_wdata_i    ( st_wdata     ),
    .st_gnt_o      ( st_gnt       ),
    .sp_rdata_i    ( sp_rdata     ),
    .sp_en_o       ( sp_en        ),
    .sp_we_o       ( sp_we        ),
    .sp_addr_o     ( sp_addr      ),
    .sp_wdata_o    ( sp_wdata     ),
    .rdata_o       ( rdata        )
  );

  mm_scratchpad u_scratchpad (
    .clk_i   ( clk_i    ),
    .en_i    ( sp_en    ),
    .we_i    ( sp_we    ),
    .addr_i  ( sp_addr  ),
    .wdata_i ( sp_wdata ),
    .rdata_o ( sp_rdata )
  );

  mm_loader u_loader (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .start_i     ( start     ),
    .x_base_i    ( x_base    ),
    .w_base_i    ( w_base    ),
    .y_base_i    ( y_base    ),
    .gnt_i       ( ld_gnt    ),
    .rdata_i     ( rdata     ),
    .req_o       ( ld_req    ),
    .addr_o      ( ld_addr   ),
    .x_o         ( x_mat     ),
    .w_o         ( w_mat     ),
    .y_o         ( y_mat     ),
    .load_done_o ( load_done )
  );

  mm_engine u_engine (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .load_done_i ( load_done ),
    .x_i         ( x_mat     ),
    .w_i         ( w_mat     ),
    .y_i         ( y_mat     ),
    .z_o         ( z_mat     ),
    .calc_done_o ( calc_done )
  );

  mm_storer u_storer (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .calc_done_i  ( calc_done  ),
    .z_base_i     ( z_base     ),
    .z_i          ( z_mat      ),
    .gnt_i        ( st_gnt     ),
    .req_o        ( st_req     ),
    .addr_o       ( st_addr    ),
    .wdata_o      ( st_wdata   ),
    .store_done_o ( store_done )
  );

endmodule

// File: design/mm_storer.sv
// Result store sequencer; packs the Z matrix into words and writes them from the Z base upward
`timescale 1ns/100ps

module mm_storer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      calc_done_i,
  input  logic [mm_pkg::ADDR_W-1:0] z_base_i,
  input  mm_pkg::mat_t              z_i,
  input  logic                      gnt_i,
  output logic                      req_o,
  output logic [mm_pkg::ADDR_W-1:0] addr_o,
  output logic [mm_pkg::WORD_W-1:0] wdata_o,
  output logic                      store_done_o
);

  logic                      active_q;
  logic [mm_pkg::WIDX_W-1:0] cnt_q;
  mm_pkg::mat_t              z_q;
  mm_pkg::mem_word_u         wr_word;

  assign req_o   = active_q;
  assign addr_o  = z_base_i + {{(mm_pkg::ADDR_W-mm_pkg::WIDX_W){1'b0}}, cnt_q};
  assign wdata_o = wr_word.raw;

  always_comb begin
    for (int e = 0; e < mm_pkg::ELEMS_PER_WORD; e++) begin
      wr_word.elem[e] = z_q[cnt_q[mm_pkg::WIDX_W-1:1]][{cnt_q[0], e[0]}];
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_done_i) begin
      z_q <= z_i;
    end
  end

  // Request stays up until granted, one word per grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q     <= 1'b0;
      cnt_q        <= '0;
      store_done_o <= 1'b0;
    end else begin
      store_done_o <= 1'b0;
      if (calc_done_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q && gnt_i) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == mm_pkg::WORDS_PER_MAT - 1) begin
          active_q     <= 1'b0;
          store_done_o <= 1'b1;
        end
      end
    end
  end

endmodule

// File: design/mm_engine.sv
// Multiply-accumulate array computing Z = X*W + Y, one inner-product step per cycle
`timescale 1ns/100ps

module mm_engine (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         load_done_i,
  input  mm_pkg::mat_t x_i,
  input  mm_pkg::mat_t w_i,
  input  mm_pkg::mat_t y_i,
  output mm_pkg::mat_t z_o,
  output logic         calc_done_o
);

  logic                      run_q;
  logic [mm_pkg::STEP_W-1:0] k_q;
  mm_pkg::mat_t              acc_q;

  assign z_o = acc_q;

  // Accumulators start from the Y bias, sums wrap at element width
  always_ff @(posedge clk_i) begin
    if (load_done_i) begin
      acc_q <= y_i;
    end else if (run_q) begin
      for (int i = 0; i < mm_pkg::MAT_N; i++) begin
        for (int j = 0; j < mm_pkg::MAT_N; j++) begin
          acc_q[i][j] <= acc_q[i][j] + x_i[i][k_q] * w_i[k_q][j];
        end
      end
    end
  end

  // Step counter walks k over the shared dimension
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q       <= 1'b0;
      k_q         <= '0;
      calc_done_o <= 1'b0;
    end else begin
      calc_done_o <= 1'b0;
      if (load_done_i) begin
        run_q <= 1'b1;
        k_q   <= '0;
      end else if (run_q) begin
        k_q <= k_q + 1'b1;
        if (k_q == mm_pkg::MAT_N - 1) begin
          run_q       <= 1'b0;
          calc_done_o <= 1'b1;
        end
      end
    end
  end

endmodule

// File: design/mm_loader.sv
// Operand fetch sequencer; reads X, W and Y words in turn and unpacks them into matrices
`timescale 1ns/100ps

module mm_loader (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  logic [mm_pkg::ADDR_W-1:0] x_base_i,
  input  logic [mm_pkg::ADDR_W-1:0] w_base_i,
  input  logic [mm_pkg::ADDR_W-1:0] y_base_i,
  input  logic                      gnt_i,
  input  logic [mm_pkg::WORD_W-1:0] rdata_i,
  output logic                      req_o,
  output logic [mm_pkg::ADDR_W-1:0] addr_o,
  output mm_pkg::mat_t              x_o,
  output mm_pkg::mat_t              w_o,
  output mm_pkg::mat_t              y_o,
  output logic                      load_done_o
);

  logic                          active_q, pending_q;
  logic [mm_pkg::LOAD_CNT_W-1:0] cnt_q;
  logic [mm_pkg::WIDX_W-1:0]     widx;
  logic [1:0]                    region;
  logic [mm_pkg::ADDR_W-1:0]     base;
  mm_pkg::mem_word_u             rd_word;

  // Upper counter bits pick the matrix, lower bits the word in it
  assign widx        = cnt_q[mm_pkg::WIDX_W-1:0];
  assign region      = cnt_q[mm_pkg::LOAD_CNT_W-1:mm_pkg::WIDX_W];
  assign rd_word.raw = rdata_i;
  assign req_o       = active_q && !pending_q;

  always_comb begin
    case (region)
      2'd0:    base = x_base_i;
      2'd1:    base = w_base_i;
      default: base = y_base_i;
    endcase
  end

  assign addr_o = base + {{(mm_pkg::ADDR_W-mm_pkg::WIDX_W){1'b0}}, widx};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q    <= 1'b0;
      pending_q   <= 1'b0;
      cnt_q       <= '0;
      load_done_o <= 1'b0;
    end else begin
      load_done_o <= 1'b0;
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (req_o && gnt_i) begin
        pending_q <= 1'b1;
      end else if (pending_q) begin
        // Data for the outstanding read is on the bus now
        pending_q <= 1'b0;
        cnt_q     <= cnt_q + 1'b1;
        if (cnt_q == mm_pkg::LOAD_WORDS - 1) begin
          active_q    <= 1'b0;
          load_done_o <= 1'b1;
        end
      end
    end
  end

  // Two words per row, lower column in the low half
  always_ff @(posedge clk_i) begin
    if (pending_q) begin
      for (int e = 0; e < mm_pkg::ELEMS_PER_WORD; e++) begin
        case (region)
          2'd0:    x_o[widx[mm_pkg::WIDX_W-1:1]][{widx[0], e[0]}] <= rd_word.elem[e];
          2'd1:    w_o[widx[mm_pkg::WIDX_W-1:1]][{widx[0], e[0]}] <= rd_word.elem[e];
          default: y_o[widx[mm_pkg::WIDX_W-1:1]][{widx[0], e[0]}] <= rd_word.elem[e];
        endcase
      end
    end
  end

endmodule

// File: design/mm_scratchpad.sv
// Single-port scratchpad memory with a registered read, one access per cycle
`timescale 1ns/100ps

module mm_scratchpad (
  input  logic                      clk_i,
  input  logic                      en_i,
  input  logic                      we_i,
  input  logic [mm_pkg::ADDR_W-1:0] addr_i,
  input  logic [mm_pkg::WORD_W-1:0] wdata_i,
  output logic [mm_pkg::WORD_W-1:0] rdata_o
);

  mm_pkg::mem_word_u mem [2**mm_pkg::ADDR_W];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i].raw <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i].raw;
      end
    end
  end

endmodule

// File: design/mm_mem_arbiter.sv
// Fixed-priority arbiter sharing the single scratchpad port between host, loader and storer
`timescale 1ns/100ps

module mm_mem_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  logic [mm_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [mm_pkg::WORD_W-1:0] host_wdata_i,
  output logic                      host_gnt_o,
  output logic                      host_rvalid_o,
  input  logic                      ld_req_i,
  input  logic                      ld_we_i,
  input  logic [mm_pkg::ADDR_W-1:0] ld_addr_i,
  input  logic [mm_pkg::WORD_W-1:0] ld_wdata_i,
  output logic                      ld_gnt_o,
  input  logic                      st_req_i,
  input  logic                      st_we_i,
  input  logic [mm_pkg::ADDR_W-1:0] st_addr_i,
  input  logic [mm_pkg::WORD_W-1:0] st_wdata_i,
  output logic                      st_gnt_o,
  input  logic [mm_pkg::WORD_W-1:0] sp_rdata_i,
  output logic                      sp_en_o,
  output logic                      sp_we_o,
  output logic [mm_pkg::ADDR_W-1:0] sp_addr_o,
  output logic [mm_pkg::WORD_W-1:0] sp_wdata_o,
  output logic [mm_pkg::WORD_W-1:0] rdata_o
);

  // Host first, then loader, then storer
  assign host_gnt_o = host_req_i;
  assign ld_gnt_o   = ld_req_i && !host_req_i;
  assign st_gnt_o   = st_req_i && !host_req_i && !ld_req_i;
  assign sp_en_o    = host_req_i || ld_req_i || st_req_i;

  always_comb begin
    if (host_req_i) begin
      sp_we_o    = host_we_i;
      sp_addr_o  = host_addr_i;
      sp_wdata_o = host_wdata_i;
    end else if (ld_req_i) begin
      sp_we_o    = ld_we_i;
      sp_addr_o  = ld_addr_i;
      sp_wdata_o = ld_wdata_i;
    end else begin
      sp_we_o    = st_we_i;
      sp_addr_o  = st_addr_i;
      sp_wdata_o = st_wdata_i;
    end
  end

  // Only host reads raise the host valid strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      host_rvalid_o <= 1'b0;
    end else begin
      host_rvalid_o <= host_req_i && !host_we_i;
    end
  end

  // Read data is shared, each peer samples it the cycle after its grant
  assign rdata_o = sp_rdata_i;

endmodule

// File: design/mm_regfile.sv
// Host-visible register file; holds base addresses, starts jobs and reports busy and done count
`timescale 1ns/100ps

module mm_regfile (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [mm_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [mm_pkg::WORD_W-1:0]     reg_wdata_i,
  input  logic                          store_done_i,
  output logic [mm_pkg::WORD_W-1:0]     reg_rdata_o,
  output logic                          reg_rvalid_o,
  output logic [mm_pkg::ADDR_W-1:0]     x_base_o,
  output logic [mm_pkg::ADDR_W-1:0]     w_base_o,
  output logic [mm_pkg::ADDR_W-1:0]     y_base_o,
  output logic [mm_pkg::ADDR_W-1:0]     z_base_o,
  output logic                          start_o,
  output logic                          busy_o,
  output logic                          done_o
);

  logic                          busy_q;
  logic [mm_pkg::DONE_CNT_W-1:0] done_cnt_q;
  logic [mm_pkg::WORD_W-1:0]     rdata_d;
  logic                          wr_en, launch;

  assign wr_en  = reg_req_i && reg_we_i;
  // Triggers that arrive mid-job are dropped
  assign launch = wr_en && (reg_addr_i == mm_pkg::REG_TRIGGER) && !busy_q;
  assign busy_o = busy_q;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (reg_addr_i)
        mm_pkg::REG_X_BASE: x_base_o <= reg_wdata_i[mm_pkg::ADDR_W-1:0];
        mm_pkg::REG_W_BASE: w_base_o <= reg_wdata_i[mm_pkg::ADDR_W-1:0];
        mm_pkg::REG_Y_BASE: y_base_o <= reg_wdata_i[mm_pkg::ADDR_W-1:0];
        mm_pkg::REG_Z_BASE: z_base_o <= reg_wdata_i[mm_pkg::ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      mm_pkg::REG_X_BASE: rdata_d[mm_pkg::ADDR_W-1:0] = x_base_o;
      mm_pkg::REG_W_BASE: rdata_d[mm_pkg::ADDR_W-1:0] = w_base_o;
      mm_pkg::REG_Y_BASE: rdata_d[mm_pkg::ADDR_W-1:0] = y_base_o;
      mm_pkg::REG_Z_BASE: rdata_d[mm_pkg::ADDR_W-1:0] = z_base_o;
      mm_pkg::REG_STATUS: begin
        rdata_d[mm_pkg::STATUS_BUSY_BIT] = busy_q;
        rdata_d[mm_pkg::STATUS_CNT_LSB +: mm_pkg::DONE_CNT_W] = done_cnt_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i && !reg_we_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      done_cnt_q   <= '0;
      start_o      <= 1'b0;
      done_o       <= 1'b0;
      reg_rvalid_o <= 1'b0;
    end else begin
      start_o      <= launch;
      done_o       <= store_done_i;
      reg_rvalid_o <= reg_req_i && !reg_we_i;
      if (launch) begin
        busy_q <= 1'b1;
      end else if (store_done_i) begin
        busy_q <= 1'b0;
      end
      if (store_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: design/mm_pkg.sv
// Shared sizes, register map and data types for the matrix-multiply accelerator, used by scoped name
package mm_pkg;

  // Matrix geometry and element format
  localparam int MAT_N          = 4;
  localparam int ELEM_W         = 16;
  localparam int WORD_W         = 32;
  localparam int ELEMS_PER_WORD = 2;
  localparam int WORDS_PER_MAT  = 8;

  // Scratchpad and sequencer sizing
  localparam int ADDR_W     = 8;
  localparam int WIDX_W     = $clog2(WORDS_PER_MAT);
  localparam int LOAD_WORDS = 3 * WORDS_PER_MAT;
  localparam int LOAD_CNT_W = $clog2(LOAD_WORDS);
  localparam int STEP_W     = $clog2(MAT_N);

  // Register map
  localparam int REG_ADDR_W = 3;
  localparam logic [REG_ADDR_W-1:0] REG_X_BASE  = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_W_BASE  = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_Y_BASE  = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_Z_BASE  = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER = 3'd4;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 3'd5;

  // Status register layout
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_CNT_LSB  = 8;
  localparam int DONE_CNT_W      = 8;

  typedef logic signed [ELEM_W-1:0] elem_t;

  // Row-major, indexed as m[row][col]
  typedef elem_t [MAT_N-1:0][MAT_N-1:0] mat_t;

  // Lower column index lives in the low half of the word
  typedef union packed {
    logic [WORD_W-1:0]          raw;
    elem_t [ELEMS_PER_WORD-1:0] elem;
  } mem_word_u;

endpackage
